// File: common/memBusIf.sv
`default_nettype none
`timescale 1ns/1ps

interface memBusIf;

    logic [31:2] addr;
    logic [3:0]  byteEn;
    logic [31:0] wData;
    logic [31:0] rData;

    // Store preparation side
    modport master (
        output addr,
        output byteEn,
        output wData,
        input  rData
    );

    // Memory array side
    modport slave (
        input  addr,
        input  byteEn,
        input  wData,
        output rData
    );

endinterface

`default_nettype wire

// File: common/memStagePkg.sv
`default_nettype none

package memStagePkg;

    // Operation currently held in the memory stage
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB,
        OP_MFC0,
        OP_MTC0,
        OP_ERET,
        OP_ALU
    } memOp_e;

    // Matches the Cause[6:2] field
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } excCode_e;

    // Interrupts share code zero with the no-exception case
    localparam excCode_e EXC_INT = EXC_NONE;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        KCTRL_NONE,
        KCTRL_ENTRY,
        KCTRL_ERET
    } kernelCtrl_e;

    // SR as written by MTC0 and as read by the interrupt logic
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] rsvdHi;
            logic [5:0]  im;
            logic [7:0]  rsvdLo;
            logic        exl;
            logic        ie;
        } f;
    } cp0Status_u;

endpackage

`default_nettype wire

// File: common/memStage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data memory window with an exclusive end
`define DM_ADDR_START  32'h0000_0000
`define DM_ADDR_END    32'h0000_3000
`define DM_DEPTH_WORDS 3072

// EPC value out of reset
`define EPC_RESET      32'h0000_3000

// Read-only processor ID
`define CP0_PRID       32'hBAAD_FACE

// CP0 register numbers
`define CP0_ID_SR      5'd12
`define CP0_ID_CAUSE   5'd13
`define CP0_ID_EPC     5'd14
`define CP0_ID_PRID    5'd15

`endif

// File: dv/memStage_sva.sv
`default_nettype none
`timescale 1ns/1ps

module memStage_sva (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic                     stall,
    input wire logic                     clr,
    input wire memStagePkg::excCode_e    excCode,
    input wire logic [3:0]               byteEn,
    input wire memStagePkg::kernelCtrl_e kernelCtrl,
    input wire logic [106:0]             wbBus
);
    import memStagePkg::*;

    int assertFails = 0;

    // No lane is written while an exception is flagged
    assert property (@(posedge clk) disable iff (reset)
        (excCode != EXC_NONE) |-> (byteEn == 4'b0000))
    else begin
        assertFails++;
        $error("byteEn active during an exception");
    end

    assert property (@(posedge clk) reset |=> (kernelCtrl == KCTRL_NONE))
    else begin
        assertFails++;
        $error("kernelCtrl raised right after reset");
    end

    // Held latch keeps every write-back field
    assert property (@(posedge clk) disable iff (reset)
        (stall && !clr) |=> $stable(wbBus))
    else begin
        assertFails++;
        $error("write-back outputs moved under stall");
    end

    assert property (@(posedge clk) clr |=> (wbBus == '0))
    else begin
        assertFails++;
        $error("write-back outputs not cleared");
    end

endmodule

bind memStage memStage_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .clr        (clr),
    .excCode    (excMerged),
    .byteEn     (memBus.byteEn),
    .kernelCtrl (kernelCtrl),
    .wbBus      ({opWb, pcWb, memWordWb, offsetWb, regWriteAddrWb, regWriteDataWb})
);

`default_nettype wire

// File: dv/memStage_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "memStage_settings.svh"

module memStage_tb;
    import memStagePkg::*;

    localparam int SeedValue = 36876;
    localparam int InitWords = 16;
    localparam int RandOps = 40;
    localparam int DirectedOps = 80;
    localparam int MaxOps = InitWords + 2 * RandOps + DirectedOps;
    localparam int WatchdogNs = (MaxOps + 3) * 10 + 500;
    localparam logic [31:0] TestBase = 32'h0000_0100;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic        clr;
    memOp_e      op;
    logic [31:0] aluOut;
    logic [31:0] storeData;
    logic [31:0] pc;
    excCode_e    excIn;
    logic        memDisable;
    logic [4:0]  cp0Id;
    logic [31:0] cp0Pc;
    logic        bdFlag;
    logic [5:0]  hwInt;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;

    kernelCtrl_e kernelCtrl;
    logic [31:2] epc;
    logic        isBd;
    memOp_e      opWb;
    logic [31:0] pcWb;
    logic [31:0] memWordWb;
    logic [1:0]  offsetWb;
    logic [4:0]  regWriteAddrWb;
    logic [31:0] regWriteDataWb;

    // Reference byte shadow of the memory and the CP0 registers
    logic [7:0]  shadow [0:4*`DM_DEPTH_WORDS-1];
    logic [5:0]  srIm;
    logic        srExl;
    logic        srIe;
    logic [5:0]  causeIp;
    logic [4:0]  causeCode;
    logic        causeBd;
    logic [31:0] epcModel;
    logic [31:0] epcShown;
    logic [31:0] wbNext [0:5];
    logic [31:0] wbShown [0:5];
    kernelCtrl_e kExp = KCTRL_NONE;
    logic        bdExp = 1'b0;
    logic        checkOn = 1'b0;
    logic [31:0] pcCount = 32'h0040_0000;

    // Side inputs that apply to the next issued operation only
    logic [5:0]  pendIrq = 6'b0;
    logic        pendBd = 1'b0;
    logic        pendStall = 1'b0;
    logic        pendClr = 1'b0;
    logic        pendDis = 1'b0;
    excCode_e    pendExc = EXC_NONE;

    memStage u_dut (.*);

    always #5 clk = ~clk;

    function automatic logic isLoadOp(input memOp_e o);
        return (o == OP_LW) || (o == OP_LH) || (o == OP_LHU) || (o == OP_LB) || (o == OP_LBU);
    endfunction

    function automatic logic isStoreOp(input memOp_e o);
        return (o == OP_SW) || (o == OP_SH) || (o == OP_SB);
    endfunction

    // Word seen by a load with the window wrapped onto the array
    function automatic logic [31:0] memWordAt(input logic [31:0] a);
        int base;
        base = int'(a[31:2] % `DM_DEPTH_WORDS) * 4;
        return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endfunction

    // Little-endian MIPS store of the low bytes of the data
    task automatic shadowStore(input memOp_e o, input logic [31:0] a, input logic [31:0] d);
        int b;
        int i;
        b = int'(a);
        case (o)
            OP_SW: begin
                for (i = 0; i < 4; i++) begin
                    shadow[b+i] = d[8*i +: 8];
                end
            end
            OP_SH: begin
                shadow[b] = d[7:0];
                shadow[b+1] = d[15:8];
            end
            OP_SB: shadow[b] = d[7:0];
            default: ;
        endcase
    endtask

    function automatic excCode_e addrFault(input memOp_e o, input logic [31:0] a);
        logic bad;
        bad = (a >= `DM_ADDR_END);
        if (o == OP_LW || o == OP_SW) begin
            bad = bad || (a % 4 != 0);
        end
        if (o == OP_LH || o == OP_LHU || o == OP_SH) begin
            bad = bad || (a % 2 != 0);
        end
        if (isLoadOp(o) && bad) begin
            return EXC_ADEL;
        end
        if (isStoreOp(o) && bad) begin
            return EXC_ADES;
        end
        return EXC_NONE;
    endfunction

    function automatic logic [31:0] cp0Read(input logic [4:0] id);
        case (id)
            `CP0_ID_SR:    return {16'h0, srIm, 8'h0, srExl, srIe};
            `CP0_ID_CAUSE: return {causeBd, 15'h0, causeIp, 3'b000, causeCode, 2'b00};
            `CP0_ID_EPC:   return epcModel;
            `CP0_ID_PRID:  return `CP0_PRID;
            default:       return 32'h0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Drives one operation for one cycle and advances the reference model
    task automatic issue(input memOp_e o, input logic [31:0] a, input logic [31:0] d,
                         input logic [4:0] id);
        excCode_e    exc;
        logic        intr;
        logic        entry;
        logic [31:0] result;
        @(posedge clk);
        #1;
        wbShown = wbNext;
        epcShown = epcModel;
        op = o;
        aluOut = a;
        storeData = d;
        cp0Id = id;
        pc = pcCount;
        cp0Pc = (pcCount - 32'd8) | 32'($urandom_range(3, 0));
        pcCount = pcCount + 32'd4;
        regWriteAddr = 5'($urandom);
        regWriteData = $urandom;
        hwInt = pendIrq;
        bdFlag = pendBd;
        stall = pendStall;
        clr = pendClr;
        memDisable = pendDis;
        excIn = pendExc;
        pendIrq = 6'b0;
        pendBd = 1'b0;
        pendStall = 1'b0;
        pendClr = 1'b0;
        pendDis = 1'b0;
        pendExc = EXC_NONE;
        checkOn = 1'b1;

        exc = (excIn != EXC_NONE) ? excIn : addrFault(o, a);
        intr = (|(hwInt & srIm)) && srIe && !srExl;
        entry = intr || (exc != EXC_NONE);
        kExp = entry ? KCTRL_ENTRY : ((o == OP_ERET) ? KCTRL_ERET : KCTRL_NONE);
        bdExp = entry && bdFlag;

        if (clr) begin
            wbNext = '{default: 32'h0};
        end else if (!stall) begin
            result = (o == OP_MFC0) ? cp0Read(id) : (isLoadOp(o) ? memWordAt(a) : regWriteData);
            wbNext = '{32'(o), pc, memWordAt(a), 32'(a[1:0]), 32'(regWriteAddr), result};
        end

        if (isStoreOp(o) && (exc == EXC_NONE) && !memDisable) begin
            shadowStore(o, a, d);
        end

        causeIp = hwInt;
        if (entry) begin
            srExl = 1'b1;
            causeCode = intr ? 5'd0 : exc;
            causeBd = bdFlag;
            epcModel = {cp0Pc[31:2], 2'b00} - (bdFlag ? 32'd4 : 32'd0);
        end else if (o == OP_ERET) begin
            srExl = 1'b0;
            causeCode = 5'd0;
            causeBd = 1'b0;
        end else if (o == OP_MTC0 && id == `CP0_ID_SR) begin
            srIm = d[15:10];
            srExl = d[1];
            srIe = d[0];
        end else if (o == OP_MTC0 && id == `CP0_ID_EPC) begin
            epcModel = {d[31:2], 2'b00};
        end
    endtask

    // Faulting access followed by reads of Cause, EPC and the home word
    task automatic probeFault(input memOp_e o, input logic [31:0] a, input logic [31:0] home);
        issue(o, a, $urandom, 5'd0);
        issue(OP_MFC0, home, 32'h0, `CP0_ID_CAUSE);
        issue(OP_MFC0, home, 32'h0, `CP0_ID_EPC);
        issue(OP_LW, home, 32'h0, 5'd0);
    endtask

    // Compare at mid-cycle where inputs and registered outputs have settled
    always @(negedge clk) begin
        if (checkOn) begin
            checkValue("kernelCtrl", 32'(kernelCtrl), 32'(kExp));
            checkValue("isBd", 32'(isBd), 32'(bdExp));
            checkValue("epc", {epc, 2'b00}, epcShown);
            checkValue("opWb", 32'(opWb), wbShown[0]);
            checkValue("pcWb", pcWb, wbShown[1]);
            checkValue("memWordWb", memWordWb, wbShown[2]);
            checkValue("offsetWb", 32'(offsetWb), wbShown[3]);
            checkValue("regWriteAddrWb", 32'(regWriteAddrWb), wbShown[4]);
            checkValue("regWriteDataWb", regWriteDataWb, wbShown[5]);
        end
        if (u_dut.u_sva.assertFails != 0) begin
            $display("Error: a bound assertion failed at time %0t", $time);
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Error: the run did not finish in time, stopped at %0t", $time);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          k;
        int          off;
        logic [31:0] a;
        memOp_e      o;
        void'($urandom(SeedValue));
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        op = OP_NOP;
        aluOut = 32'h0;
        storeData = 32'h0;
        pc = 32'h0;
        excIn = EXC_NONE;
        memDisable = 1'b0;
        cp0Id = 5'd0;
        cp0Pc = 32'h0;
        bdFlag = 1'b0;
        hwInt = 6'b0;
        regWriteAddr = 5'd0;
        regWriteData = 32'h0;
        srIm = 6'h3F;
        srExl = 1'b0;
        srIe = 1'b1;
        causeIp = 6'b0;
        causeCode = 5'd0;
        causeBd = 1'b0;
        epcModel = `EPC_RESET;
        wbNext = '{default: 32'h0};
        // Idle cycle after reset latches word zero
        wbNext[2] = memWordAt(32'h0);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Known contents for the test words
        for (k = 0; k < InitWords; k++) begin
            issue(OP_SW, TestBase + 32'(4 * k), $urandom, 5'd0);
        end

        // Random stores that are each read back as a word
        repeat (RandOps) begin
            k = $urandom_range(InitWords - 1, 0);
            case ($urandom_range(2, 0))
                0: begin
                    o = OP_SW;
                    off = 0;
                end
                1: begin
                    o = OP_SH;
                    off = 2 * $urandom_range(1, 0);
                end
                default: begin
                    o = OP_SB;
                    off = $urandom_range(3, 0);
                end
            endcase
            a = TestBase + 32'(4 * k);
            issue(o, a + 32'(off), $urandom, 5'd0);
            issue(OP_LW, a, 32'h0, 5'd0);
        end

        // Address exceptions
        probeFault(OP_SW, TestBase + 32'd5, TestBase + 32'd4);
        probeFault(OP_SH, TestBase + 32'd9, TestBase + 32'd8);
        probeFault(OP_LW, TestBase + 32'd2, TestBase);
        probeFault(OP_LHU, TestBase + 32'd3, TestBase);
        probeFault(OP_SB, 32'h0000_3100, TestBase);
        probeFault(OP_LW, 32'h0000_4000, TestBase);
        pendExc = EXC_OV;
        probeFault(OP_SB, TestBase + 32'd13, TestBase + 32'd12);
        // Earlier stage code wins over a local misalignment
        pendExc = EXC_RI;
        probeFault(OP_LW, TestBase + 32'd6, TestBase + 32'd4);

        // CP0 register access
        issue(OP_ERET, TestBase, 32'h0, 5'd0);
        repeat (4) begin
            a = {16'h0, 6'($urandom), 8'h0, 2'($urandom)};
            issue(OP_MTC0, TestBase, a, `CP0_ID_SR);
            issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_SR);
        end
        issue(OP_MTC0, TestBase, $urandom, `CP0_ID_EPC);
        issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_EPC);
        issue(OP_MTC0, TestBase, $urandom, `CP0_ID_PRID);
        issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_PRID);
        issue(OP_MFC0, TestBase, 32'h0, 5'd0);
        issue(OP_MFC0, TestBase, 32'h0, 5'd5);
        issue(OP_MFC0, TestBase, 32'h0, 5'd20);
        issue(OP_MFC0, TestBase, 32'h0, 5'd31);

        // Interrupt masking, EXL blocking, ERET and branch delay
        issue(OP_MTC0, TestBase, 32'h0000_0401, `CP0_ID_SR);
        pendIrq = 6'b000010;
        issue(OP_NOP, TestBase, 32'h0, 5'd0);
        pendIrq = 6'b000001;
        issue(OP_NOP, TestBase, 32'h0, 5'd0);
        issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_CAUSE);
        pendIrq = 6'b000001;
        issue(OP_NOP, TestBase, 32'h0, 5'd0);
        issue(OP_ERET, TestBase, 32'h0, 5'd0);
        pendIrq = 6'b000001;
        pendBd = 1'b1;
        issue(OP_NOP, TestBase, 32'h0, 5'd0);
        issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_CAUSE);
        issue(OP_MFC0, TestBase, 32'h0, `CP0_ID_EPC);
        issue(OP_ERET, TestBase, 32'h0, 5'd0);
        issue(OP_MTC0, TestBase, 32'h0000_FC00, `CP0_ID_SR);
        pendIrq = 6'h3F;
        issue(OP_NOP, TestBase, 32'h0, 5'd0);

        // Stall, clear and a disabled store
        issue(OP_ALU, TestBase, 32'h0, 5'd0);
        repeat (3) begin
            pendStall = 1'b1;
            issue(OP_ALU, TestBase + 32'd4, 32'h0, 5'd0);
        end
        pendClr = 1'b1;
        issue(OP_ALU, TestBase, 32'h0, 5'd0);
        issue(OP_ALU, TestBase, 32'h0, 5'd0);
        pendDis = 1'b1;
        issue(OP_SW, TestBase + 32'd8, $urandom, 5'd0);
        issue(OP_LW, TestBase + 32'd8, 32'h0, 5'd0);
        issue(OP_NOP, TestBase, 32'h0, 5'd0);

        @(negedge clk);
        #1;
        if (u_dut.u_sva.assertFails == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Error: %0d assertion failures", u_dut.u_sva.assertFails);
            $display("Result: FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: memStage/accessPrep.sv
`default_nettype none
`timescale 1ns/1ps
`include "memStage_settings.svh"

module accessPrep (
    input  wire memStagePkg::memOp_e   op,
    input  wire logic [31:0]           addr,
    input  wire logic [31:0]           storeData,
    input  wire memStagePkg::excCode_e excIn,
    input  wire logic                  memDisable,
    output logic [1:0]                 offset,
    output memStagePkg::excCode_e      excOut,
    memBusIf.master                    mem
);
    import memStagePkg::*;

    logic       isLoad;
    logic       isStore;
    logic       inWindow;
    logic       misaligned;
    excCode_e   excLocal;
    logic [3:0] laneMask;
    logic [31:0] laneData;

    assign mem.addr = addr[31:2];
    assign offset   = addr[1:0];

    assign isLoad  = (op == OP_LW) || (op == OP_LH) || (op == OP_LHU) ||
                     (op == OP_LB) || (op == OP_LBU);
    assign isStore = (op == OP_SW) || (op == OP_SH) || (op == OP_SB);

    assign inWindow = (addr >= `DM_ADDR_START) && (addr < `DM_ADDR_END);

    // Word accesses need both low bits clear, halfwords only bit 0
    always_comb begin
        misaligned = 1'b0;
        case (op)
            OP_LW, OP_SW:         misaligned = (addr[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: misaligned = addr[0];
            default:              misaligned = 1'b0;
        endcase
    end

    always_comb begin
        excLocal = EXC_NONE;
        if (isLoad && (misaligned || !inWindow)) begin
            excLocal = EXC_ADEL;
        end else if (isStore && (misaligned || !inWindow)) begin
            excLocal = EXC_ADES;
        end
    end

    // Earlier stage exception has priority
    assign excOut = (excIn != EXC_NONE) ? excIn : excLocal;

    // Lane steering for sub-word stores
    always_comb begin
        laneMask = 4'b0000;
        laneData = storeData;
        case (op)
            OP_SW: begin
                laneMask = 4'b1111;
            end
            OP_SH: begin
                laneMask = 4'b0011 << {offset[1], 1'b0};
                laneData = storeData << {offset[1], 4'b0000};
            end
            OP_SB: begin
                laneMask = 4'b0001 << offset;
                laneData = storeData << {offset, 3'b000};
            end
            default: begin
                laneMask = 4'b0000;
            end
        endcase
    end

    assign mem.wData  = laneData;
    assign mem.byteEn = (memDisable || (excOut != EXC_NONE)) ? 4'b0000 : laneMask;

endmodule

`default_nettype wire

// File: memStage/coprocessor0.sv
`default_nettype none
`timescale 1ns/1ps
`include "memStage_settings.svh"

module coprocessor0 (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire memStagePkg::memOp_e   op,
    input  wire logic [4:0]            cp0Id,
    input  wire logic [31:0]           wData,
    input  wire logic [31:0]           pc,
    input  wire logic                  bdFlag,
    input  wire logic [5:0]            hwInt,
    input  wire memStagePkg::excCode_e exc,
    output memStagePkg::kernelCtrl_e   kernelCtrl,
    output logic                       isBd,
    output logic [31:2]                epc,
    output logic [31:0]                rData
);
    import memStagePkg::*;

    // IM all set, IE set, EXL clear
    localparam logic [31:0] SrResetValue = 32'h0000_FC01;
    // Only IM, EXL and IE are writable
    localparam logic [31:0] SrWriteMask  = 32'h0000_FC03;

    cp0Status_u  sr;
    logic [5:0]  ip;
    excCode_e    excCode;
    logic        bd;
    logic [31:0] epcReg;
    logic [31:0] causeWord;
    logic        intReq;
    logic        excReq;
    logic        entry;

    assign intReq = (|(hwInt & sr.f.im)) && sr.f.ie && !sr.f.exl;
    assign excReq = (exc != EXC_NONE);
    assign entry  = intReq || excReq;

    assign kernelCtrl = entry ? KCTRL_ENTRY :
                        (op == OP_ERET) ? KCTRL_ERET : KCTRL_NONE;
    assign isBd = entry && bdFlag;
    assign epc  = epcReg[31:2];

    // BD at 31, IP at 15:10, code at 6:2
    assign causeWord = {bd, 15'b0, ip, 3'b000, excCode, 2'b00};

    always_comb begin
        rData = 32'h0;
        if (op == OP_MFC0) begin
            case (cp0Id)
                `CP0_ID_SR:    rData = sr.raw;
                `CP0_ID_CAUSE: rData = causeWord;
                `CP0_ID_EPC:   rData = epcReg;
                `CP0_ID_PRID:  rData = `CP0_PRID;
                default:       rData = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sr.raw  <= SrResetValue;
            ip      <= 6'b0;
            excCode <= EXC_NONE;
            bd      <= 1'b0;
            epcReg  <= `EPC_RESET;
        end else begin
            // Pending lines are sampled every cycle
            ip <= hwInt;
            if (entry) begin
                sr.f.exl <= 1'b1;
                excCode  <= intReq ? EXC_INT : exc;
                bd       <= bdFlag;
                epcReg   <= (bdFlag ? (pc - 32'd4) : pc) & 32'hFFFF_FFFC;
            end else if (op == OP_ERET) begin
                sr.f.exl <= 1'b0;
                excCode  <= EXC_NONE;
                bd       <= 1'b0;
            end else if (op == OP_MTC0) begin
                if (cp0Id == `CP0_ID_SR) begin
                    sr.raw <= wData & SrWriteMask;
                end else if (cp0Id == `CP0_ID_EPC) begin
                    epcReg <= {wData[31:2], 2'b00};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: memStage/dataMemory.sv
`default_nettype none
`timescale 1ns/1ps
`include "memStage_settings.svh"

module dataMemory (
    input  wire logic clk,
    input  wire logic reset,
    memBusIf.slave    mem
);

    localparam int IdxWidth = $clog2(`DM_DEPTH_WORDS);

    logic [31:0]         words [0:`DM_DEPTH_WORDS-1];
    logic [IdxWidth-1:0] wordIdx;

    // Out-of-window addresses fold back into the array
    assign wordIdx = IdxWidth'(mem.addr % `DM_DEPTH_WORDS);

    assign mem.rData = words[wordIdx];

    // Contents survive reset, but no lane is written while it is held
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (mem.byteEn[0]) begin
                words[wordIdx][7:0] <= mem.wData[7:0];
            end
            if (mem.byteEn[1]) begin
                words[wordIdx][15:8] <= mem.wData[15:8];
            end
            if (mem.byteEn[2]) begin
                words[wordIdx][23:16] <= mem.wData[23:16];
            end
            if (mem.byteEn[3]) begin
                words[wordIdx][31:24] <= mem.wData[31:24];
            end
        end
    end

endmodule

`default_nettype wire

// File: memStage/memStage.sv
`default_nettype none
`timescale 1ns/1ps

module memStage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  stall,
    input  wire logic                  clr,
    input  wire memStagePkg::memOp_e   op,
    input  wire logic [31:0]           aluOut,
    input  wire logic [31:0]           storeData,
    input  wire logic [31:0]           pc,
    input  wire memStagePkg::excCode_e excIn,
    input  wire logic                  memDisable,
    input  wire logic [4:0]            cp0Id,
    input  wire logic [31:0]           cp0Pc,
    input  wire logic                  bdFlag,
    input  wire logic [5:0]            hwInt,
    input  wire logic [4:0]            regWriteAddr,
    input  wire logic [31:0]           regWriteData,
    output memStagePkg::kernelCtrl_e   kernelCtrl,
    output logic [31:2]                epc,
    output logic                       isBd,
    output memStagePkg::memOp_e        opWb,
    output logic [31:0]                pcWb,
    output logic [31:0]                memWordWb,
    output logic [1:0]                 offsetWb,
    output logic [4:0]                 regWriteAddrWb,
    output logic [31:0]                regWriteDataWb
);
    import memStagePkg::*;

    logic [1:0]  offset;
    excCode_e    excMerged;
    logic [31:0] cp0RData;

    memBusIf memBus ();

    accessPrep u_accessPrep (
        .op         (op),
        .addr       (aluOut),
        .storeData  (storeData),
        .excIn      (excIn),
        .memDisable (memDisable),
        .offset     (offset),
        .excOut     (excMerged),
        .mem        (memBus.master)
    );

    dataMemory u_dataMemory (
        .clk   (clk),
        .reset (reset),
        .mem   (memBus.slave)
    );

    // Exception code here already includes the earlier stage
    coprocessor0 u_coprocessor0 (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .cp0Id      (cp0Id),
        .wData      (storeData),
        .pc         (cp0Pc),
        .bdFlag     (bdFlag),
        .hwInt      (hwInt),
        .exc        (excMerged),
        .kernelCtrl (kernelCtrl),
        .isBd       (isBd),
        .epc        (epc),
        .rData      (cp0RData)
    );

    resultLatch u_resultLatch (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .op             (op),
        .pc             (pc),
        .memWord        (memBus.rData),
        .cp0Data        (cp0RData),
        .offset         (offset),
        .regWriteAddr   (regWriteAddr),
        .regWriteData   (regWriteData),
        .opWb           (opWb),
        .pcWb           (pcWb),
        .memWordWb      (memWordWb),
        .offsetWb       (offsetWb),
        .regWriteAddrWb (regWriteAddrWb),
        .regWriteDataWb (regWriteDataWb)
    );

endmodule

`default_nettype wire

// File: memStage/resultLatch.sv
`default_nettype none
`timescale 1ns/1ps

module resultLatch (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                stall,
    input  wire logic                clr,
    input  wire memStagePkg::memOp_e op,
    input  wire logic [31:0]         pc,
    input  wire logic [31:0]         memWord,
    input  wire logic [31:0]         cp0Data,
    input  wire logic [1:0]          offset,
    input  wire logic [4:0]          regWriteAddr,
    input  wire logic [31:0]         regWriteData,
    output memStagePkg::memOp_e      opWb,
    output logic [31:0]              pcWb,
    output logic [31:0]              memWordWb,
    output logic [1:0]               offsetWb,
    output logic [4:0]               regWriteAddrWb,
    output logic [31:0]              regWriteDataWb
);
    import memStagePkg::*;

    logic        isLoad;
    logic [31:0] resultData;

    assign isLoad = (op == OP_LW) || (op == OP_LH) || (op == OP_LHU) ||
                    (op == OP_LB) || (op == OP_LBU);

    // Write-back data source
    assign resultData = (op == OP_MFC0) ? cp0Data :
                        isLoad          ? memWord : regWriteData;

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            opWb           <= OP_NOP;
            pcWb           <= 32'h0;
            memWordWb      <= 32'h0;
            offsetWb       <= 2'b00;
            regWriteAddrWb <= 5'd0;
            regWriteDataWb <= 32'h0;
        end else if (!stall) begin
            opWb           <= op;
            pcWb           <= pc;
            memWordWb      <= memWord;
            offsetWb       <= offset;
            regWriteAddrWb <= regWriteAddr;
            regWriteDataWb <= resultData;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/memStagePkg.sv
common/memBusIf.sv
memStage/accessPrep.sv
memStage/dataMemory.sv
memStage/coprocessor0.sv
memStage/resultLatch.sv
memStage/memStage.sv
dv/memStage_sva.sv
dv/memStage_tb.sv
